// File: logic/axi_bridge_pkg.sv
// Bus widths, FIFO sizing and enum types shared by every block of the AXI4 to Lite write bridge
package axi_bridge_pkg;

  // ==================================================
  // Bus widths
  // ==================================================
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int STRB_W  = 4;
  localparam int ID_W    = 4;
  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int PROT_W  = 3;
  localparam int RESP_W  = 2;

  // ==================================================
  // FIFO sizing
  // ==================================================
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  // One extra code so a full FIFO can be told from an empty one
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // ==================================================
  // Encodings
  // ==================================================
  typedef enum logic [BURST_W-1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_t;

  typedef enum logic [RESP_W-1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

  // Splitter FSM
  typedef enum logic [1:0] {
    SPLIT_IDLE,
    SPLIT_ISSUE,
    SPLIT_DONE
  } split_state_t;

  // Merger FSM
  typedef enum logic [1:0] {
    MERGE_IDLE,
    MERGE_COLLECT,
    MERGE_SEND
  } merge_state_t;

endpackage

// File: logic/sync_fifo.sv
// Synchronous valid/ready FIFO of FIFO_DEPTH entries, instantiated for each queue in the bridge
`timescale 1ns/1ps

module sync_fifo
  import axi_bridge_pkg::*;
#(
  parameter int WIDTH = 8
)
(
  input  logic             clk,
  input  logic             rstn,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  logic [WIDTH-1:0]      mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  push;
  logic                  pop;

  // Pointer step with wrap at the last entry
  function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
    if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  assign in_ready  = (count != FIFO_CNT_W'(FIFO_DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      // Push and pop together leave the count unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

endmodule

// File: logic/burst_splitter.sv
// Takes one AXI4 AW burst at a time, issues its per-beat Lite addresses and hands ID/len to the merger
`timescale 1ns/1ps

module burst_splitter
  import axi_bridge_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  // AXI4 AW channel
  input  logic              s_aw_valid,
  output logic              s_aw_ready,
  input  logic [ID_W-1:0]   s_aw_id,
  input  logic [ADDR_W-1:0] s_aw_addr,
  input  logic [LEN_W-1:0]  s_aw_len,
  input  logic [SIZE_W-1:0] s_aw_size,
  input  burst_t            s_aw_burst,
  input  logic [PROT_W-1:0] s_aw_prot,
  // Single-beat addresses toward the AW FIFO
  output logic              beat_valid,
  input  logic              beat_ready,
  output logic [ADDR_W-1:0] beat_addr,
  output logic [PROT_W-1:0] beat_prot,
  // Burst info toward the response merger
  output logic              info_valid,
  input  logic              info_ready,
  output logic [ID_W-1:0]   info_id,
  output logic [LEN_W-1:0]  info_len
);

  split_state_t state;
  split_state_t state_n;

  logic [ID_W-1:0]   id_r;
  logic [ADDR_W-1:0] addr_r;
  logic [ADDR_W-1:0] aligned_r;
  logic [LEN_W-1:0]  len_r;
  logic [SIZE_W-1:0] size_r;
  burst_t            burst_r;
  logic [PROT_W-1:0] prot_r;
  logic [LEN_W-1:0]  beat_cnt;

  logic aw_hs;
  logic beat_hs;
  logic last_beat;

  assign aw_hs     = s_aw_valid & s_aw_ready;
  assign beat_hs   = beat_valid & beat_ready;
  assign last_beat = (beat_cnt == len_r);

  // ==================================================
  // FSM
  // ==================================================
  always_comb
  begin
    state_n = state;
    case (state)
      SPLIT_IDLE:
        if (aw_hs)
          state_n = SPLIT_ISSUE;
      SPLIT_ISSUE:
        if (beat_hs && last_beat)
          state_n = SPLIT_DONE;
      SPLIT_DONE:
        if (info_ready)
          state_n = SPLIT_IDLE;
      default:
        state_n = SPLIT_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      state    <= SPLIT_IDLE;
      beat_cnt <= '0;
    end
    else
    begin
      state <= state_n;
      if (aw_hs)
        beat_cnt <= '0;
      else if (beat_hs)
        beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // ==================================================
  // Burst capture
  // ==================================================
  always_ff @(posedge clk)
  begin
    if (aw_hs)
    begin
      id_r      <= s_aw_id;
      addr_r    <= s_aw_addr;
      aligned_r <= s_aw_addr & ({ADDR_W{1'b1}} << s_aw_size);
      len_r     <= s_aw_len;
      size_r    <= s_aw_size;
      burst_r   <= s_aw_burst;
      prot_r    <= s_aw_prot;
    end
  end

  // Beat address; WRAP follows the INCR rule here
  always_comb
  begin
    if (burst_r == BURST_FIXED || beat_cnt == '0)
      beat_addr = addr_r;
    else
      beat_addr = aligned_r + (ADDR_W'(beat_cnt) << size_r);
  end

  assign s_aw_ready = (state == SPLIT_IDLE);
  assign beat_valid = (state == SPLIT_ISSUE);
  assign beat_prot  = prot_r;
  assign info_valid = (state == SPLIT_DONE);
  assign info_id    = id_r;
  assign info_len   = len_r;

endmodule

// File: logic/resp_merger.sv
// Gathers the len+1 Lite write responses of a burst and returns one AXI4 B response in order
`timescale 1ns/1ps

module resp_merger
  import axi_bridge_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  // Burst info from the splitter
  input  logic              info_valid,
  output logic              info_ready,
  input  logic [ID_W-1:0]   info_id,
  input  logic [LEN_W-1:0]  info_len,
  // Lite responses from the B FIFO
  input  logic              resp_valid,
  output logic              resp_ready,
  input  resp_t             resp,
  // AXI4 B channel
  output logic              s_b_valid,
  input  logic              s_b_ready,
  output logic [ID_W-1:0]   s_b_id,
  output logic [RESP_W-1:0] s_b_resp
);

  merge_state_t state;
  merge_state_t state_n;

  logic [ID_W-1:0]  id_r;
  logic [LEN_W-1:0] len_r;
  logic [LEN_W-1:0] resp_cnt;
  resp_t            resp_r;

  logic info_hs;
  logic resp_hs;

  assign info_hs = info_valid & info_ready;
  assign resp_hs = resp_valid & resp_ready;

  // ==================================================
  // FSM
  // ==================================================
  always_comb
  begin
    state_n = state;
    case (state)
      MERGE_IDLE:
        if (info_hs)
          state_n = MERGE_COLLECT;
      MERGE_COLLECT:
        if (resp_hs && resp_cnt == len_r)
          state_n = MERGE_SEND;
      MERGE_SEND:
        if (s_b_ready)
          state_n = MERGE_IDLE;
      default:
        state_n = MERGE_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      state    <= MERGE_IDLE;
      resp_cnt <= '0;
    end
    else
    begin
      state <= state_n;
      if (info_hs)
        resp_cnt <= '0;
      else if (resp_hs)
        resp_cnt <= resp_cnt + 1'b1;
    end
  end

  // ==================================================
  // Response accumulation
  // ==================================================
  always_ff @(posedge clk)
  begin
    if (info_hs)
    begin
      id_r   <= info_id;
      len_r  <= info_len;
      resp_r <= RESP_OKAY;
    end
    else if (resp_hs && resp_r == RESP_OKAY)
      resp_r <= resp;   // first error code sticks
  end

  assign info_ready = (state == MERGE_IDLE);
  assign resp_ready = (state == MERGE_COLLECT);
  assign s_b_valid  = (state == MERGE_SEND);
  assign s_b_id     = id_r;
  assign s_b_resp   = resp_r;

endmodule

// File: logic/axi4_lite_write_bridge.sv
// Top level of the AXI4 to AXI4-Lite write bridge, connecting splitter, FIFOs and merger to both buses
`timescale 1ns/1ps

module axi4_lite_write_bridge
  import axi_bridge_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  // AXI4 slave AW
  input  logic              s_aw_valid,
  output logic              s_aw_ready,
  input  logic [ID_W-1:0]   s_aw_id,
  input  logic [ADDR_W-1:0] s_aw_addr,
  input  logic [LEN_W-1:0]  s_aw_len,
  input  logic [SIZE_W-1:0] s_aw_size,
  input  logic [BURST_W-1:0] s_aw_burst,
  input  logic [PROT_W-1:0] s_aw_prot,
  // AXI4 slave W
  // Last has no Lite counterpart and is not forwarded
  input  logic              s_w_valid,
  output logic              s_w_ready,
  input  logic [DATA_W-1:0] s_w_data,
  input  logic [STRB_W-1:0] s_w_strb,
  input  logic              s_w_last,
  // AXI4 slave B
  output logic              s_b_valid,
  input  logic              s_b_ready,
  output logic [ID_W-1:0]   s_b_id,
  output logic [RESP_W-1:0] s_b_resp,
  // Lite master AW
  output logic              m_aw_valid,
  input  logic              m_aw_ready,
  output logic [ADDR_W-1:0] m_aw_addr,
  output logic [PROT_W-1:0] m_aw_prot,
  // Lite master W
  output logic              m_w_valid,
  input  logic              m_w_ready,
  output logic [DATA_W-1:0] m_w_data,
  output logic [STRB_W-1:0] m_w_strb,
  // Lite master B
  input  logic              m_b_valid,
  output logic              m_b_ready,
  input  logic [RESP_W-1:0] m_b_resp
);

  logic                     beat_valid;
  logic                     beat_ready;
  logic [ADDR_W-1:0]        beat_addr;
  logic [PROT_W-1:0]        beat_prot;
  logic                     info_valid;
  logic                     info_ready;
  logic [ID_W-1:0]          info_id;
  logic [LEN_W-1:0]         info_len;
  logic [PROT_W+ADDR_W-1:0] aw_fifo_out;
  logic [DATA_W+STRB_W-1:0] w_fifo_out;
  logic                     b_fifo_valid;
  logic                     b_fifo_ready;
  logic [RESP_W-1:0]        b_fifo_resp;

  burst_splitter u_splitter (
    .clk        (clk),
    .rstn       (rstn),
    .s_aw_valid (s_aw_valid),
    .s_aw_ready (s_aw_ready),
    .s_aw_id    (s_aw_id),
    .s_aw_addr  (s_aw_addr),
    .s_aw_len   (s_aw_len),
    .s_aw_size  (s_aw_size),
    .s_aw_burst (burst_t'(s_aw_burst)),
    .s_aw_prot  (s_aw_prot),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .beat_addr  (beat_addr),
    .beat_prot  (beat_prot),
    .info_valid (info_valid),
    .info_ready (info_ready),
    .info_id    (info_id),
    .info_len   (info_len)
  );

  // ==================================================
  // Beat, data and response queues
  // ==================================================
  sync_fifo #(.WIDTH(PROT_W + ADDR_W)) u_aw_fifo (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (beat_valid),
    .in_ready  (beat_ready),
    .in_data   ({beat_prot, beat_addr}),
    .out_valid (m_aw_valid),
    .out_ready (m_aw_ready),
    .out_data  (aw_fifo_out)
  );

  sync_fifo #(.WIDTH(DATA_W + STRB_W)) u_w_fifo (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (s_w_valid),
    .in_ready  (s_w_ready),
    .in_data   ({s_w_data, s_w_strb}),
    .out_valid (m_w_valid),
    .out_ready (m_w_ready),
    .out_data  (w_fifo_out)
  );

  sync_fifo #(.WIDTH(RESP_W)) u_b_fifo (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (m_b_valid),
    .in_ready  (m_b_ready),
    .in_data   (m_b_resp),
    .out_valid (b_fifo_valid),
    .out_ready (b_fifo_ready),
    .out_data  (b_fifo_resp)
  );

  assign {m_aw_prot, m_aw_addr} = aw_fifo_out;
  assign {m_w_data, m_w_strb}   = w_fifo_out;

  resp_merger u_merger (
    .clk        (clk),
    .rstn       (rstn),
    .info_valid (info_valid),
    .info_ready (info_ready),
    .info_id    (info_id),
    .info_len   (info_len),
    .resp_valid (b_fifo_valid),
    .resp_ready (b_fifo_ready),
    .resp       (resp_t'(b_fifo_resp)),
    .s_b_valid  (s_b_valid),
    .s_b_ready  (s_b_ready),
    .s_b_id     (s_b_id),
    .s_b_resp   (s_b_resp)
  );

endmodule

// File: bench/axi4_lite_write_bridge_assert.sv
// Handshake-stability checks on the bridge's AXI4 B and Lite AW channels, bound into the top level
`timescale 1ns/1ps

module axi4_lite_write_bridge_assert
  import axi_bridge_pkg::*;
(
  input logic              clk,
  input logic              rstn,
  input logic              s_b_valid,
  input logic              s_b_ready,
  input logic [ID_W-1:0]   s_b_id,
  input logic [RESP_W-1:0] s_b_resp,
  input logic              m_aw_valid,
  input logic              m_aw_ready,
  input logic [ADDR_W-1:0] m_aw_addr
);

  int fail_count = 0;

  // B held with its payload until taken
  a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
    s_b_valid && !s_b_ready |=> s_b_valid && $stable(s_b_id) && $stable(s_b_resp))
  else
  begin
    $error("s_b_valid or the B payload changed before s_b_ready");
    fail_count++;
  end

  a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
    m_aw_valid && !m_aw_ready |=> m_aw_valid && $stable(m_aw_addr))
  else
  begin
    $error("m_aw_valid or m_aw_addr changed before m_aw_ready");
    fail_count++;
  end

  // One cycle after a reset edge the merger is idle
  a_b_reset: assert property (@(posedge clk) !rstn |=> !s_b_valid)
  else
  begin
    $error("s_b_valid high during reset");
    fail_count++;
  end

endmodule

// File: bench/tb_axi4_lite_write_bridge.sv
// Drives AXI4 write bursts into the bridge, models a Lite slave and checks every beat and B response
`timescale 1ns/1ps

module tb_axi4_lite_write_bridge
  import axi_bridge_pkg::*;
();

  logic               clk = 1'b0;
  logic               rstn = 1'b0;
  logic               s_aw_valid = 1'b0;
  logic               s_aw_ready;
  logic [ID_W-1:0]    s_aw_id = '0;
  logic [ADDR_W-1:0]  s_aw_addr = '0;
  logic [LEN_W-1:0]   s_aw_len = '0;
  logic [SIZE_W-1:0]  s_aw_size = '0;
  logic [BURST_W-1:0] s_aw_burst = '0;
  logic [PROT_W-1:0]  s_aw_prot = '0;
  logic               s_w_valid = 1'b0;
  logic               s_w_ready;
  logic [DATA_W-1:0]  s_w_data = '0;
  logic [STRB_W-1:0]  s_w_strb = '0;
  logic               s_w_last = 1'b0;
  logic               s_b_valid;
  logic               s_b_ready = 1'b0;
  logic [ID_W-1:0]    s_b_id;
  logic [RESP_W-1:0]  s_b_resp;
  logic               m_aw_valid;
  logic               m_aw_ready = 1'b0;
  logic [ADDR_W-1:0]  m_aw_addr;
  logic [PROT_W-1:0]  m_aw_prot;
  logic               m_w_valid;
  logic               m_w_ready = 1'b0;
  logic [DATA_W-1:0]  m_w_data;
  logic [STRB_W-1:0]  m_w_strb;
  logic               m_b_valid = 1'b0;
  logic               m_b_ready;
  logic [RESP_W-1:0]  m_b_resp = '0;

  // {id, addr, len, size, burst, prot}
  logic [ID_W+ADDR_W+LEN_W+SIZE_W+BURST_W+PROT_W-1:0] aw_cmd_q[$];
  // {data, strb, last}
  logic [DATA_W+STRB_W:0]     w_cmd_q[$];
  logic [PROT_W+ADDR_W-1:0]   exp_aw_q[$];
  logic [PROT_W+ADDR_W-1:0]   obs_aw_q[$];
  logic [DATA_W+STRB_W-1:0]   exp_w_q[$];
  logic [DATA_W+STRB_W-1:0]   obs_w_q[$];
  logic [ID_W+RESP_W-1:0]     exp_b_q[$];
  logic [ID_W+RESP_W-1:0]     obs_b_q[$];
  logic [ADDR_W-1:0]          slv_addr_q[$];
  int                         slv_w_cnt = 0;
  logic                       stall_en = 1'b0;
  string                      test_name = "reset";

  axi4_lite_write_bridge u_dut (.*);

  bind axi4_lite_write_bridge axi4_lite_write_bridge_assert u_assert (.*);

  initial
  begin
    forever #4 clk = ~clk;
  end

  // ==================================================
  // Reference model
  // ==================================================
  function automatic logic [ADDR_W-1:0] beat_addr_ref(input logic [ADDR_W-1:0] addr,
                                                      input logic [SIZE_W-1:0] size,
                                                      input burst_t burst, input int n);
    logic [ADDR_W-1:0] aligned;
    aligned = (addr >> size) << size;
    if (burst == BURST_FIXED || n == 0)
      return addr;
    else
      return aligned + ADDR_W'(n) * (ADDR_W'(1) << size);
  endfunction

  // Lite slave answers with an error inside the 0xF00 page
  function automatic resp_t lite_resp_for(input logic [ADDR_W-1:0] addr);
    return (addr[11:8] == 4'hF) ? RESP_SLVERR : RESP_OKAY;
  endfunction

  function automatic resp_t merge_resp_ref(input logic [ADDR_W-1:0] addr,
                                           input logic [LEN_W-1:0] len,
                                           input logic [SIZE_W-1:0] size, input burst_t burst);
    resp_t merged;
    merged = RESP_OKAY;
    for (int n = 0; n <= len; n++)
      if (merged == RESP_OKAY)
        merged = lite_resp_for(beat_addr_ref(addr, size, burst, n));
    return merged;
  endfunction

  function automatic logic ready_draw();
    if (stall_en)
      return ($urandom_range(3) != 0);
    else
      return 1'b1;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped on first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual)
      stop_with_failure($sformatf("ERR %s expected %0h actual %0h", name, expected, actual));
  endtask

  task automatic queue_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                             input logic [LEN_W-1:0] len, input logic [SIZE_W-1:0] size,
                             input burst_t burst, input logic [PROT_W-1:0] prot);
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    aw_cmd_q.push_back({id, addr, len, size, burst, prot});
    for (int n = 0; n <= len; n++)
    begin
      data = $urandom;
      strb = $urandom;
      w_cmd_q.push_back({data, strb, n == len});
      exp_aw_q.push_back({prot, beat_addr_ref(addr, size, burst, n)});
      exp_w_q.push_back({data, strb});
    end
    exp_b_q.push_back({id, merge_resp_ref(addr, len, size, burst)});
  endtask

  // IDs wrap after 16 bursts, so any 16 in a row are distinct
  task automatic queue_random_burst(input int idx);
    logic [ADDR_W-1:0] addr;
    burst_t            burst;
    addr = $urandom;
    if ($urandom_range(2) == 0)
      addr[11:8] = 4'hF;
    burst = ($urandom_range(1) == 0) ? BURST_FIXED : BURST_INCR;
    queue_burst(ID_W'(idx), addr, LEN_W'($urandom_range(7)), SIZE_W'($urandom_range(2)),
                burst, PROT_W'($urandom));
  endtask

  task automatic wait_bursts_done();
    int cycles;
    cycles = 0;
    while ((exp_aw_q.size() != 0 || exp_w_q.size() != 0) && cycles < 5000)
    begin
      @(posedge clk);
      cycles++;
    end
    if (exp_aw_q.size() != 0 || exp_w_q.size() != 0)
      stop_with_failure($sformatf("Timeout in %s waiting for Lite AW and W beats", test_name));
    cycles = 0;
    while (exp_b_q.size() != 0 && cycles < 5000)
    begin
      @(posedge clk);
      cycles++;
    end
    if (exp_b_q.size() != 0)
      stop_with_failure($sformatf("Timeout in %s waiting for AXI4 B responses", test_name));
    @(negedge clk);
  endtask

  // ==================================================
  // AXI4 master and Lite slave
  // ==================================================
  always @(posedge clk)
  begin
    if (rstn)
    begin
      if (!s_aw_valid || s_aw_ready)
      begin
        s_aw_valid <= (aw_cmd_q.size() != 0);
        if (aw_cmd_q.size() != 0)
          {s_aw_id, s_aw_addr, s_aw_len, s_aw_size, s_aw_burst, s_aw_prot} <= aw_cmd_q.pop_front();
      end
      if (!s_w_valid || s_w_ready)
      begin
        s_w_valid <= (w_cmd_q.size() != 0);
        if (w_cmd_q.size() != 0)
          {s_w_data, s_w_strb, s_w_last} <= w_cmd_q.pop_front();
      end
      if (s_b_valid && s_b_ready)
        obs_b_q.push_back({s_b_id, s_b_resp});
      s_b_ready <= ready_draw();
    end
  end

  always @(posedge clk)
  begin
    if (rstn)
    begin
      if (m_aw_valid && m_aw_ready)
      begin
        slv_addr_q.push_back(m_aw_addr);
        obs_aw_q.push_back({m_aw_prot, m_aw_addr});
      end
      if (m_w_valid && m_w_ready)
      begin
        slv_w_cnt++;
        obs_w_q.push_back({m_w_data, m_w_strb});
      end
      // Pair AW and W in arrival order, answer once both are in
      if (!m_b_valid || m_b_ready)
      begin
        m_b_valid <= (slv_addr_q.size() != 0 && slv_w_cnt != 0);
        if (slv_addr_q.size() != 0 && slv_w_cnt != 0)
        begin
          m_b_resp <= lite_resp_for(slv_addr_q.pop_front());
          slv_w_cnt--;
        end
      end
      m_aw_ready <= ready_draw();
      m_w_ready  <= ready_draw();
    end
  end

  // ==================================================
  // Compare
  // ==================================================
  always @(negedge clk)
  begin
    if (u_dut.u_assert.fail_count != 0)
      stop_with_failure("A handshake assertion on the bridge failed");
    if (obs_aw_q.size() != 0)
    begin
      if (exp_aw_q.size() == 0)
        stop_with_failure("A Lite AW transfer arrived with no beat expected");
      else
        check_value({test_name, " m_aw"}, exp_aw_q.pop_front(), obs_aw_q.pop_front());
    end
    if (obs_w_q.size() != 0)
    begin
      if (exp_w_q.size() == 0)
        stop_with_failure("A Lite W transfer arrived with no data expected");
      else
        check_value({test_name, " m_w"}, exp_w_q.pop_front(), obs_w_q.pop_front());
    end
    if (obs_b_q.size() != 0)
    begin
      if (exp_b_q.size() == 0)
        stop_with_failure("An AXI4 B response arrived with no burst outstanding");
      else
        check_value({test_name, " s_b"}, exp_b_q.pop_front(), obs_b_q.pop_front());
    end
  end

  initial
  begin
    int i;
    void'($urandom(32'h70cb_4755));
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);

    // Idle bridge right after reset
    check_value({test_name, " s_aw_ready"}, 1'b1, s_aw_ready);
    check_value({test_name, " s_w_ready"}, 1'b1, s_w_ready);
    check_value({test_name, " m_b_ready"}, 1'b1, m_b_ready);
    check_value({test_name, " m_aw_valid"}, 1'b0, m_aw_valid);
    check_value({test_name, " m_w_valid"}, 1'b0, m_w_valid);
    check_value({test_name, " s_b_valid"}, 1'b0, s_b_valid);

    test_name = "single_beat";
    queue_burst(4'h3, 32'h0000_1234, 8'd0, 3'd2, BURST_INCR, 3'b010);
    wait_bursts_done();

    test_name = "incr_unaligned";
    queue_burst(4'h5, 32'h0000_2006, 8'd3, 3'd2, BURST_INCR, 3'b000);
    wait_bursts_done();

    test_name = "fixed_burst";
    queue_burst(4'h6, 32'h0000_3010, 8'd2, 3'd2, BURST_FIXED, 3'b001);
    wait_bursts_done();

    // Later beats of the first burst land in the error page
    test_name = "resp_merge";
    queue_burst(4'h9, 32'h0000_0EF8, 8'd3, 3'd2, BURST_INCR, 3'b000);
    queue_burst(4'hA, 32'h0000_0E00, 8'd3, 3'd2, BURST_INCR, 3'b000);
    // Error beats come first here and OKAY beats follow
    queue_burst(4'hB, 32'h0000_1FF8, 8'd3, 3'd2, BURST_INCR, 3'b000);
    wait_bursts_done();

    test_name = "random_overlap";
    stall_en = 1'b1;
    for (i = 0; i < 20; i++)
      queue_random_burst(i);
    wait_bursts_done();

    repeat (20) @(negedge clk);
    if (u_dut.u_assert.fail_count != 0)
      stop_with_failure("Handshake assertions failed during the run");
    else
    begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// File: axi4_lite_write_bridge.f
logic/axi_bridge_pkg.sv
logic/sync_fifo.sv
logic/burst_splitter.sv
logic/resp_merger.sv
logic/axi4_lite_write_bridge.sv
bench/axi4_lite_write_bridge_assert.sv
bench/tb_axi4_lite_write_bridge.sv

// File: Bender.yml
package:
  name: axi4_lite_write_bridge

sources:
  - logic/axi_bridge_pkg.sv
  - logic/sync_fifo.sv
  - logic/burst_splitter.sv
  - logic/resp_merger.sv
  - logic/axi4_lite_write_bridge.sv
  - target: test
    files:
      - bench/axi4_lite_write_bridge_assert.sv
      - bench/tb_axi4_lite_write_bridge.sv
